//--- include/db_settings.svh
`ifndef DB_SETTINGS_SVH
`define DB_SETTINGS_SVH

// Settings bus base for the whole daughterboard control block
`define DB_SR_BASE        8'd160

// Block offsets from the settings base
`define DB_SR_MISC        8'd0
`define DB_SR_SPI         8'd8
`define DB_SR_LEDS        8'd16
`define DB_SR_FP_GPIO     8'd24
`define DB_SR_DB_GPIO     8'd32

// Register offsets inside one GPIO bank
`define GPIO_OFF_IDLE     8'd0
`define GPIO_OFF_RX       8'd1
`define GPIO_OFF_TX       8'd2
`define GPIO_OFF_FDX      8'd3
`define GPIO_OFF_DDR      8'd4
`define GPIO_OFF_FAB      8'd5

// Register offsets inside the SPI core, a data write starts a transfer
`define SPI_OFF_DIV       8'd0
`define SPI_OFF_CTRL      8'd1
`define SPI_OFF_DATA      8'd2

// Readback addresses start here
`define DB_RB_BASE        8'd16
`define DB_RB_BADADDR     64'h0BADC0DE_0BADC0DE

// Reset values
`define GPIO_DEFAULT_DDR  32'hFFFF_FFFF

`endif

//--- verilog/db_pkg.sv
`default_nettype none

package db_pkg;

  // Radio run state as seen by the ATR banks
  typedef enum logic [1:0] {
    ATR_IDLE = 2'd0,
    ATR_RX   = 2'd1,
    ATR_TX   = 2'd2,
    ATR_FDX  = 2'd3
  } atr_state_t;

  // SPI transfer phases
  typedef enum logic [1:0] {
    SPI_IDLE  = 2'd0,
    SPI_SETUP = 2'd1,
    SPI_SHIFT = 2'd2,
    SPI_HOLD  = 2'd3
  } spi_state_t;

  // Readback offsets from the readback base
  typedef enum logic [2:0] {
    RB_MISC_IO = 3'd0,
    RB_SPI     = 3'd1,
    RB_LEDS    = 3'd2,
    RB_DB_GPIO = 3'd3,
    RB_FP_GPIO = 3'd4
  } rb_sel_t;

endpackage

`default_nettype wire

//--- verilog/gpio_atr.sv
`timescale 1ns/1ps
`default_nettype none

`include "db_settings.svh"

module gpio_atr #(
  parameter logic [7:0] BASE        = 8'd0,
  parameter bit         FAB_CTRL_EN = 1'b1
) (
  input  wire         clk,
  input  wire         reset,
  input  wire         i_set_stb,
  input  wire  [7:0]  i_set_addr,
  input  wire  [31:0] i_set_data,
  input  wire         i_run_rx,
  input  wire         i_run_tx,
  input  wire  [31:0] i_gpio_in,
  input  wire  [31:0] i_gpio_fab,
  output logic [31:0] o_gpio_out,
  output logic [31:0] o_gpio_ddr,
  output logic [31:0] o_gpio_rb
);

  import db_pkg::*;

  localparam logic [7:0] ADDR_IDLE = BASE + `GPIO_OFF_IDLE;
  localparam logic [7:0] ADDR_RX   = BASE + `GPIO_OFF_RX;
  localparam logic [7:0] ADDR_TX   = BASE + `GPIO_OFF_TX;
  localparam logic [7:0] ADDR_FDX  = BASE + `GPIO_OFF_FDX;
  localparam logic [7:0] ADDR_DDR  = BASE + `GPIO_OFF_DDR;
  localparam logic [7:0] ADDR_FAB  = BASE + `GPIO_OFF_FAB;

  atr_state_t  atr_state;
  logic [31:0] reg_idle;
  logic [31:0] reg_rx;
  logic [31:0] reg_tx;
  logic [31:0] reg_fdx;
  logic [31:0] fab_mask;
  logic [31:0] atr_out;

  // Registered run state, so outputs follow run_rx/run_tx one cycle later
  always_ff @(posedge clk) begin
    if (reset) begin
      atr_state <= ATR_IDLE;
    end else begin
      case ({i_run_tx, i_run_rx})
        2'b01:   atr_state <= ATR_RX;
        2'b10:   atr_state <= ATR_TX;
        2'b11:   atr_state <= ATR_FDX;
        default: atr_state <= ATR_IDLE;
      endcase
    end
  end

  // Output word per state and the direction register
  always_ff @(posedge clk) begin
    if (reset) begin
      reg_idle   <= '0;
      reg_rx     <= '0;
      reg_tx     <= '0;
      reg_fdx    <= '0;
      o_gpio_ddr <= `GPIO_DEFAULT_DDR;
    end else if (i_set_stb) begin
      case (i_set_addr)
        ADDR_IDLE: reg_idle   <= i_set_data;
        ADDR_RX:   reg_rx     <= i_set_data;
        ADDR_TX:   reg_tx     <= i_set_data;
        ADDR_FDX:  reg_fdx    <= i_set_data;
        ADDR_DDR:  o_gpio_ddr <= i_set_data;
        default:   ;
      endcase
    end
  end

  // Fabric mask only exists on banks that the fabric may drive
  if (FAB_CTRL_EN) begin : g_fab
    always_ff @(posedge clk) begin
      if (reset) begin
        fab_mask <= '0;
      end else if (i_set_stb && (i_set_addr == ADDR_FAB)) begin
        fab_mask <= i_set_data;
      end
    end
  end else begin : g_no_fab
    assign fab_mask = '0;
  end

  always_comb begin
    case (atr_state)
      ATR_RX:  atr_out = reg_rx;
      ATR_TX:  atr_out = reg_tx;
      ATR_FDX: atr_out = reg_fdx;
      default: atr_out = reg_idle;
    endcase
  end

  // Masked bits come straight from the fabric
  assign o_gpio_out = (atr_out & ~fab_mask) | (i_gpio_fab & fab_mask);

  always_ff @(posedge clk) begin
    o_gpio_rb <= i_gpio_in;
  end

endmodule

`default_nettype wire

//--- verilog/simple_spi_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "db_settings.svh"

module simple_spi_core #(
  parameter logic [7:0] BASE = 8'd0
) (
  input  wire         clk,
  input  wire         reset,
  input  wire         i_set_stb,
  input  wire  [7:0]  i_set_addr,
  input  wire  [31:0] i_set_data,
  input  wire         i_miso,
  output logic [31:0] o_readback,
  output logic        o_readback_stb,
  output logic [7:0]  o_sen,
  output logic        o_sclk,
  output logic        o_mosi
);

  import db_pkg::*;

  localparam logic [7:0] ADDR_DIV  = BASE + `SPI_OFF_DIV;
  localparam logic [7:0] ADDR_CTRL = BASE + `SPI_OFF_CTRL;
  localparam logic [7:0] ADDR_DATA = BASE + `SPI_OFF_DATA;

  spi_state_t  state;
  logic [15:0] divider;
  logic [7:0]  sen_mask;
  logic [5:0]  num_bits;
  logic [5:0]  bits_left;
  logic [15:0] half_cnt;
  logic [31:0] shift_reg;
  logic [31:0] rx_reg;
  logic [5:0]  ctrl_bits;
  logic        trigger;

  assign trigger = i_set_stb && (i_set_addr == ADDR_DATA);

  // Zero and anything above 32 both mean a full 32-bit word
  assign ctrl_bits = i_set_data[13:8];

  always_ff @(posedge clk) begin
    if (reset) begin
      divider  <= '0;
      sen_mask <= '0;
      num_bits <= 6'd32;
    end else if (i_set_stb) begin
      if (i_set_addr == ADDR_DIV) begin
        divider <= i_set_data[15:0];
      end
      if (i_set_addr == ADDR_CTRL) begin
        sen_mask <= i_set_data[7:0];
        num_bits <= ((ctrl_bits == 6'd0) || (ctrl_bits > 6'd32)) ? 6'd32 : ctrl_bits;
      end
    end
  end

  // Each SCLK level and each chip-select margin lasts divider+1 cycles
  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= SPI_IDLE;
      o_sen          <= 8'hFF;
      o_sclk         <= 1'b0;
      o_readback_stb <= 1'b0;
      shift_reg      <= '0;
      half_cnt       <= '0;
      bits_left      <= '0;
    end else begin
      o_readback_stb <= 1'b0;
      case (state)
        SPI_IDLE: begin
          if (trigger) begin
            state     <= SPI_SETUP;
            o_sen     <= ~sen_mask;
            shift_reg <= i_set_data;
            rx_reg    <= '0;
            half_cnt  <= divider;
            bits_left <= num_bits;
          end
        end
        SPI_SETUP: begin
          if (half_cnt == 16'd0) begin
            state    <= SPI_SHIFT;
            o_sclk   <= 1'b1;
            rx_reg   <= {rx_reg[30:0], i_miso};
            half_cnt <= divider;
          end else begin
            half_cnt <= half_cnt - 16'd1;
          end
        end
        SPI_SHIFT: begin
          if (half_cnt != 16'd0) begin
            half_cnt <= half_cnt - 16'd1;
          end else if (o_sclk) begin
            // Falling edge, next MOSI bit goes out
            o_sclk    <= 1'b0;
            shift_reg <= {shift_reg[30:0], 1'b0};
            bits_left <= bits_left - 6'd1;
            half_cnt  <= divider;
            if (bits_left == 6'd1) begin
              state <= SPI_HOLD;
            end
          end else begin
            o_sclk   <= 1'b1;
            rx_reg   <= {rx_reg[30:0], i_miso};
            half_cnt <= divider;
          end
        end
        SPI_HOLD: begin
          if (half_cnt == 16'd0) begin
            state          <= SPI_IDLE;
            o_sen          <= 8'hFF;
            o_readback_stb <= 1'b1;
            o_readback     <= rx_reg;
          end else begin
            half_cnt <= half_cnt - 16'd1;
          end
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  // MSB first
  assign o_mosi = shift_reg[31];

  // All chip selects released whenever no transfer runs
  a_sen_idle: assert property (@(posedge clk) disable iff (reset)
    (state == SPI_IDLE) |-> (o_sen == 8'hFF));

  // Host must wait for readback strobe before the next trigger
  a_no_busy_trigger: assert property (@(posedge clk) disable iff (reset)
    trigger |-> (state == SPI_IDLE));

endmodule

`default_nettype wire

//--- verilog/db_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "db_settings.svh"

module db_control (
  input  wire         clk,
  input  wire         reset,
  input  wire         i_set_stb,
  input  wire  [7:0]  i_set_addr,
  input  wire  [31:0] i_set_data,
  input  wire  [7:0]  i_rb_addr,
  input  wire         i_run_rx,
  input  wire         i_run_tx,
  input  wire  [31:0] i_misc_ins,
  input  wire  [31:0] i_fp_gpio_in,
  input  wire  [31:0] i_fp_gpio_fab,
  input  wire  [31:0] i_db_gpio_in,
  input  wire  [31:0] i_db_gpio_fab,
  input  wire         i_miso,
  output logic        o_rb_stb,
  output logic [63:0] o_rb_data,
  output logic [31:0] o_misc_outs,
  output logic [31:0] o_fp_gpio_out,
  output logic [31:0] o_fp_gpio_ddr,
  output logic [31:0] o_db_gpio_out,
  output logic [31:0] o_db_gpio_ddr,
  output logic [31:0] o_leds,
  output logic [7:0]  o_sen,
  output logic        o_sclk,
  output logic        o_mosi
);

  import db_pkg::*;

  localparam logic [7:0] ADDR_MISC     = `DB_SR_BASE + `DB_SR_MISC;
  localparam logic [7:0] ADDR_SPI      = `DB_SR_BASE + `DB_SR_SPI;
  localparam logic [7:0] ADDR_SPI_TRIG = ADDR_SPI + `SPI_OFF_DATA;

  logic [31:0] fp_gpio_rb;
  logic [31:0] db_gpio_rb;
  logic [31:0] spi_readback;
  logic        spi_readback_stb;
  logic [31:0] spi_rb_hold;
  logic        spi_rb_stb_hold;
  logic [7:0]  rb_off;
  logic        rb_valid;
  rb_sel_t     rb_sel;

  always_ff @(posedge clk) begin
    if (reset) begin
      o_misc_outs <= '0;
    end else if (i_set_stb && (i_set_addr == ADDR_MISC)) begin
      o_misc_outs <= i_set_data;
    end
  end

  gpio_atr #(.BASE(`DB_SR_BASE + `DB_SR_LEDS), .FAB_CTRL_EN(1'b0)) leds_gpio_atr (
    .clk(clk), .reset(reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_run_rx(i_run_rx), .i_run_tx(i_run_tx),
    .i_gpio_in(32'd0), .i_gpio_fab(32'd0),
    .o_gpio_out(o_leds), .o_gpio_ddr(), .o_gpio_rb());

  gpio_atr #(.BASE(`DB_SR_BASE + `DB_SR_FP_GPIO), .FAB_CTRL_EN(1'b1)) fp_gpio_atr (
    .clk(clk), .reset(reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_run_rx(i_run_rx), .i_run_tx(i_run_tx),
    .i_gpio_in(i_fp_gpio_in), .i_gpio_fab(i_fp_gpio_fab),
    .o_gpio_out(o_fp_gpio_out), .o_gpio_ddr(o_fp_gpio_ddr), .o_gpio_rb(fp_gpio_rb));

  gpio_atr #(.BASE(`DB_SR_BASE + `DB_SR_DB_GPIO), .FAB_CTRL_EN(1'b1)) db_gpio_atr (
    .clk(clk), .reset(reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_run_rx(i_run_rx), .i_run_tx(i_run_tx),
    .i_gpio_in(i_db_gpio_in), .i_gpio_fab(i_db_gpio_fab),
    .o_gpio_out(o_db_gpio_out), .o_gpio_ddr(o_db_gpio_ddr), .o_gpio_rb(db_gpio_rb));

  simple_spi_core #(.BASE(ADDR_SPI)) spi_core (
    .clk(clk), .reset(reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_miso(i_miso),
    .o_readback(spi_readback), .o_readback_stb(spi_readback_stb),
    .o_sen(o_sen), .o_sclk(o_sclk), .o_mosi(o_mosi));

  // Ready flag stays up after a transfer so later readbacks of any address work
  always_ff @(posedge clk) begin
    if (reset) begin
      spi_rb_stb_hold <= 1'b1;
    end else if (i_set_stb && (i_set_addr == ADDR_SPI_TRIG)) begin
      spi_rb_stb_hold <= 1'b0;
    end else if (spi_readback_stb) begin
      spi_rb_stb_hold <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (spi_readback_stb) begin
      spi_rb_hold <= spi_readback;
    end
  end

  assign o_rb_stb = spi_rb_stb_hold;

  // Only the first eight readback slots can map, offsets 5 to 7 fall to the default
  assign rb_off   = i_rb_addr - `DB_RB_BASE;
  assign rb_valid = (rb_off[7:3] == 5'd0);
  assign rb_sel   = rb_sel_t'(rb_off[2:0]);

  always_comb begin
    o_rb_data = `DB_RB_BADADDR;
    if (rb_valid) begin
      case (rb_sel)
        RB_MISC_IO: o_rb_data = {i_misc_ins, o_misc_outs};
        RB_SPI:     o_rb_data = {32'd0, spi_rb_hold};
        RB_LEDS:    o_rb_data = {32'd0, o_leds};
        RB_DB_GPIO: o_rb_data = {32'd0, db_gpio_rb};
        RB_FP_GPIO: o_rb_data = {32'd0, fp_gpio_rb};
        default:    o_rb_data = `DB_RB_BADADDR;
      endcase
    end
  end

  // Readiness only returns after the SPI core reports the end of a transfer
  a_rb_stb_rise: assert property (@(posedge clk) disable iff (reset)
    $rose(o_rb_stb) |-> $past(spi_readback_stb));

endmodule

`default_nettype wire

//--- sim/db_checker.sv
`timescale 1ns/1ps
`default_nettype none

module db_checker (
  input  wire         clk,
  input  wire         reset,
  input  wire         i_chk_stb,
  input  wire  [3:0]  i_chk_sel,
  input  wire  [63:0] i_chk_exp,
  input  wire         i_done,
  input  wire         i_rb_stb,
  input  wire  [63:0] i_rb_data,
  input  wire  [31:0] i_misc_outs,
  input  wire  [31:0] i_leds,
  input  wire  [31:0] i_fp_gpio_out,
  input  wire  [31:0] i_fp_gpio_ddr,
  input  wire  [31:0] i_db_gpio_out,
  input  wire  [31:0] i_db_gpio_ddr,
  input  wire  [7:0]  i_sen,
  input  wire         i_sclk,
  output logic [31:0] o_pass_count,
  output logic [31:0] o_fail_count
);

  localparam logic [3:0] SEL_RB_DATA  = 4'd0;
  localparam logic [3:0] SEL_RB_STB   = 4'd1;
  localparam logic [3:0] SEL_MISC     = 4'd2;
  localparam logic [3:0] SEL_LEDS     = 4'd3;
  localparam logic [3:0] SEL_FP_OUT   = 4'd4;
  localparam logic [3:0] SEL_FP_DDR   = 4'd5;
  localparam logic [3:0] SEL_DB_OUT   = 4'd6;
  localparam logic [3:0] SEL_DB_DDR   = 4'd7;
  localparam logic [3:0] SEL_SEN      = 4'd8;
  localparam logic [3:0] SEL_EDGES    = 4'd9;
  localparam logic [3:0] SEL_SEN_XFER = 4'd10;

  logic [63:0] actual;
  logic        prev_sclk;
  logic [7:0]  prev_sen;
  logic [7:0]  xfer_sen;
  logic [31:0] sclk_edges;

  function automatic string sig_name(input logic [3:0] sel);
    case (sel)
      SEL_RB_DATA:  return "o_rb_data";
      SEL_RB_STB:   return "o_rb_stb";
      SEL_MISC:     return "o_misc_outs";
      SEL_LEDS:     return "o_leds";
      SEL_FP_OUT:   return "o_fp_gpio_out";
      SEL_FP_DDR:   return "o_fp_gpio_ddr";
      SEL_DB_OUT:   return "o_db_gpio_out";
      SEL_DB_DDR:   return "o_db_gpio_ddr";
      SEL_SEN:      return "o_sen";
      SEL_EDGES:    return "o_sclk rising edges";
      SEL_SEN_XFER: return "o_sen during transfer";
      default:      return "unknown signal";
    endcase
  endfunction

  always_comb begin
    case (i_chk_sel)
      SEL_RB_DATA:  actual = i_rb_data;
      SEL_RB_STB:   actual = {63'd0, i_rb_stb};
      SEL_MISC:     actual = {32'd0, i_misc_outs};
      SEL_LEDS:     actual = {32'd0, i_leds};
      SEL_FP_OUT:   actual = {32'd0, i_fp_gpio_out};
      SEL_FP_DDR:   actual = {32'd0, i_fp_gpio_ddr};
      SEL_DB_OUT:   actual = {32'd0, i_db_gpio_out};
      SEL_DB_DDR:   actual = {32'd0, i_db_gpio_ddr};
      SEL_SEN:      actual = {56'd0, i_sen};
      SEL_EDGES:    actual = {32'd0, sclk_edges};
      SEL_SEN_XFER: actual = {56'd0, xfer_sen};
      default:      actual = '0;
    endcase
  end

  // SCLK rises while a chip select is low, cleared when a transfer starts
  always @(posedge clk) begin
    if (reset) begin
      prev_sclk  <= 1'b0;
      prev_sen   <= 8'hFF;
      xfer_sen   <= 8'hFF;
      sclk_edges <= '0;
    end else begin
      prev_sclk <= i_sclk;
      prev_sen  <= i_sen;
      if ((i_sen != 8'hFF) && (prev_sen == 8'hFF)) begin
        xfer_sen   <= i_sen;
        sclk_edges <= '0;
      end else if (i_sclk && !prev_sclk && (i_sen != 8'hFF)) begin
        sclk_edges <= sclk_edges + 32'd1;
      end
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      o_pass_count <= '0;
      o_fail_count <= '0;
    end else begin
      if (i_chk_stb) begin
        if (actual === i_chk_exp) begin
          o_pass_count <= o_pass_count + 32'd1;
          $display("test %0d ok: %s = 0x%h", o_pass_count + o_fail_count + 32'd1,
                   sig_name(i_chk_sel), actual);
        end else begin
          o_fail_count <= o_fail_count + 32'd1;
          $display("mismatch %s: expected 0x%h, got 0x%h (test %0d)", sig_name(i_chk_sel),
                   i_chk_exp, actual, o_pass_count + o_fail_count + 32'd1);
        end
      end
      if (i_done) begin
        $display("checks passed: %0d, failed: %0d", o_pass_count, o_fail_count);
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_db_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "db_settings.svh"

module tb_db_control;

  import db_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int MAX_DIV      = 3;
  // Setup, 32 bit periods and hold at the slowest divider plus margin
  localparam int WORST_SPI    = (MAX_DIV + 1) * (2 * 32 + 2) + 8;

  localparam logic [3:0] OP_WRITE = 4'd0;
  localparam logic [3:0] OP_CHECK = 4'd1;
  localparam logic [3:0] OP_RUN   = 4'd2;
  localparam logic [3:0] OP_SPI   = 4'd3;
  localparam logic [3:0] OP_WAIT  = 4'd4;

  localparam logic [3:0] SEL_RB_DATA  = 4'd0;
  localparam logic [3:0] SEL_RB_STB   = 4'd1;
  localparam logic [3:0] SEL_MISC     = 4'd2;
  localparam logic [3:0] SEL_LEDS     = 4'd3;
  localparam logic [3:0] SEL_FP_OUT   = 4'd4;
  localparam logic [3:0] SEL_FP_DDR   = 4'd5;
  localparam logic [3:0] SEL_DB_OUT   = 4'd6;
  localparam logic [3:0] SEL_DB_DDR   = 4'd7;
  localparam logic [3:0] SEL_SEN      = 4'd8;
  localparam logic [3:0] SEL_EDGES    = 4'd9;
  localparam logic [3:0] SEL_SEN_XFER = 4'd10;

  localparam logic [7:0] MISC_ADDR = `DB_SR_BASE + `DB_SR_MISC;
  localparam logic [7:0] SPI_BASE  = `DB_SR_BASE + `DB_SR_SPI;
  localparam logic [7:0] LEDS_BASE = `DB_SR_BASE + `DB_SR_LEDS;
  localparam logic [7:0] FP_BASE   = `DB_SR_BASE + `DB_SR_FP_GPIO;
  localparam logic [7:0] DB_BASE   = `DB_SR_BASE + `DB_SR_DB_GPIO;

  typedef struct packed {
    logic [3:0]  op;
    logic [3:0]  sel;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [63:0] exp;
  } entry_t;

  logic        clk;
  logic        reset;
  logic        set_stb;
  logic [7:0]  set_addr;
  logic [31:0] set_data;
  logic [7:0]  rb_addr;
  logic        run_rx;
  logic        run_tx;
  logic [31:0] misc_ins;
  logic [31:0] fp_gpio_in;
  logic [31:0] fp_gpio_fab;
  logic [31:0] db_gpio_in;
  logic [31:0] db_gpio_fab;
  wire         mosi;
  wire         rb_stb;
  wire  [63:0] rb_data;
  wire  [31:0] misc_outs;
  wire  [31:0] fp_gpio_out;
  wire  [31:0] fp_gpio_ddr;
  wire  [31:0] db_gpio_out;
  wire  [31:0] db_gpio_ddr;
  wire  [31:0] leds;
  wire  [7:0]  sen;
  wire         sclk;
  logic        chk_stb;
  logic [3:0]  chk_sel;
  logic [63:0] chk_exp;
  logic        done;
  wire  [31:0] pass_count;
  wire  [31:0] fail_count;
  logic [31:0] lfsr_state;
  entry_t      table_q[$];
  int          n_checks = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  // MOSI loops back to MISO
  db_control db_control_inst (
    .clk(clk), .reset(reset),
    .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
    .i_rb_addr(rb_addr), .i_run_rx(run_rx), .i_run_tx(run_tx), .i_misc_ins(misc_ins),
    .i_fp_gpio_in(fp_gpio_in), .i_fp_gpio_fab(fp_gpio_fab),
    .i_db_gpio_in(db_gpio_in), .i_db_gpio_fab(db_gpio_fab), .i_miso(mosi),
    .o_rb_stb(rb_stb), .o_rb_data(rb_data), .o_misc_outs(misc_outs),
    .o_fp_gpio_out(fp_gpio_out), .o_fp_gpio_ddr(fp_gpio_ddr),
    .o_db_gpio_out(db_gpio_out), .o_db_gpio_ddr(db_gpio_ddr),
    .o_leds(leds), .o_sen(sen), .o_sclk(sclk), .o_mosi(mosi));

  db_checker db_checker_inst (
    .clk(clk), .reset(reset),
    .i_chk_stb(chk_stb), .i_chk_sel(chk_sel), .i_chk_exp(chk_exp), .i_done(done),
    .i_rb_stb(rb_stb), .i_rb_data(rb_data), .i_misc_outs(misc_outs), .i_leds(leds),
    .i_fp_gpio_out(fp_gpio_out), .i_fp_gpio_ddr(fp_gpio_ddr),
    .i_db_gpio_out(db_gpio_out), .i_db_gpio_ddr(db_gpio_ddr),
    .i_sen(sen), .i_sclk(sclk),
    .o_pass_count(pass_count), .o_fail_count(fail_count));

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if ((cycle_limit != 0) && (cycle_count >= cycle_limit)) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [7:0] rb_addr_of(input rb_sel_t s);
    return `DB_RB_BASE + {5'd0, s};
  endfunction

  function automatic logic [31:0] run_bits(input atr_state_t st);
    logic rx;
    logic tx;
    rx = (st == ATR_RX) || (st == ATR_FDX);
    tx = (st == ATR_TX) || (st == ATR_FDX);
    return {30'd0, tx, rx};
  endfunction

  task automatic add_entry(input logic [3:0] op, input logic [3:0] sel, input logic [7:0] addr,
                           input logic [31:0] data, input logic [63:0] exp);
    table_q.push_back(entry_t'{op, sel, addr, data, exp});
    if (op == OP_CHECK) begin
      n_checks++;
    end
  endtask

  task automatic add_check(input logic [3:0] sel, input logic [7:0] addr,
                           input logic [63:0] exp);
    add_entry(OP_CHECK, sel, addr, 32'd0, exp);
  endtask

  task automatic apply_entry(input entry_t e);
    case (e.op)
      OP_WRITE, OP_SPI: begin
        set_stb  = 1'b1;
        set_addr = e.addr;
        set_data = e.data;
        @(negedge clk);
        set_stb  = 1'b0;
      end
      OP_CHECK: begin
        rb_addr = e.addr;
        chk_sel = e.sel;
        chk_exp = e.exp;
        chk_stb = 1'b1;
        @(negedge clk);
        chk_stb = 1'b0;
      end
      OP_RUN: begin
        run_tx = e.data[1];
        run_rx = e.data[0];
        @(negedge clk);
      end
      default: begin
        // SPI transfer ends when readback is ready again
        while (!rb_stb) @(negedge clk);
      end
    endcase
  endtask

  initial begin : stimulus
    logic [31:0] w;
    logic [31:0] led_w [4];
    logic [31:0] db_w [4];
    logic [31:0] fp_idle;
    logic [31:0] fab_mask;
    logic [31:0] fp_dir;
    logic [31:0] fp_exp;
    logic [7:0]  mask;
    logic [7:0]  atr_off [4];
    int          spi_bits [3];
    int          spi_div [3];
    atr_state_t  st;

    atr_off  = '{`GPIO_OFF_IDLE, `GPIO_OFF_RX, `GPIO_OFF_TX, `GPIO_OFF_FDX};
    spi_bits = '{8, 17, 32};
    spi_div  = '{1, 0, MAX_DIV};
    clk      = 1'b0;
    reset    = 1'b1;
    set_stb  = 1'b0;
    set_addr = 8'd0;
    set_data = 32'd0;
    rb_addr  = 8'd0;
    run_rx   = 1'b0;
    run_tx   = 1'b0;
    chk_stb  = 1'b0;
    chk_sel  = 4'd0;
    chk_exp  = 64'd0;
    done     = 1'b0;
    lfsr_state = 32'h67c79208;
    take_bits(32, misc_ins);
    take_bits(32, fp_gpio_in);
    take_bits(32, fp_gpio_fab);
    take_bits(32, db_gpio_in);
    take_bits(32, db_gpio_fab);

    // Reset defaults and unmapped readback
    add_check(SEL_LEDS, 8'd0, 64'd0);
    add_check(SEL_MISC, 8'd0, 64'd0);
    add_check(SEL_FP_OUT, 8'd0, 64'd0);
    add_check(SEL_DB_OUT, 8'd0, 64'd0);
    add_check(SEL_FP_DDR, 8'd0, {32'd0, `GPIO_DEFAULT_DDR});
    add_check(SEL_DB_DDR, 8'd0, {32'd0, `GPIO_DEFAULT_DDR});
    add_check(SEL_SEN, 8'd0, {56'd0, 8'hFF});
    add_check(SEL_RB_STB, 8'd0, 64'd1);
    add_check(SEL_RB_DATA, `DB_RB_BASE + 8'd5, `DB_RB_BADADDR);
    add_check(SEL_RB_DATA, 8'd0, `DB_RB_BADADDR);

    // Misc register with inputs above outputs on readback
    take_bits(32, w);
    add_entry(OP_WRITE, 4'd0, MISC_ADDR, w, 64'd0);
    add_check(SEL_MISC, 8'd0, {32'd0, w});
    add_check(SEL_RB_DATA, rb_addr_of(RB_MISC_IO), {misc_ins, w});

    // ATR switching on LED and daughterboard banks
    for (int i = 0; i < 4; i++) begin
      take_bits(32, led_w[i]);
      take_bits(32, db_w[i]);
      add_entry(OP_WRITE, 4'd0, LEDS_BASE + atr_off[i], led_w[i], 64'd0);
      add_entry(OP_WRITE, 4'd0, DB_BASE + atr_off[i], db_w[i], 64'd0);
    end
    for (int i = 0; i < 4; i++) begin
      st = atr_state_t'(i[1:0]);
      add_entry(OP_RUN, 4'd0, 8'd0, run_bits(st), 64'd0);
      add_check(SEL_LEDS, 8'd0, {32'd0, led_w[st]});
      add_check(SEL_DB_OUT, 8'd0, {32'd0, db_w[st]});
      add_check(SEL_RB_DATA, rb_addr_of(RB_LEDS), {32'd0, led_w[st]});
    end

    // Front panel fabric mask and direction
    add_entry(OP_RUN, 4'd0, 8'd0, run_bits(ATR_IDLE), 64'd0);
    take_bits(32, fp_idle);
    take_bits(32, fab_mask);
    take_bits(32, fp_dir);
    add_entry(OP_WRITE, 4'd0, FP_BASE + `GPIO_OFF_IDLE, fp_idle, 64'd0);
    add_entry(OP_WRITE, 4'd0, FP_BASE + `GPIO_OFF_FAB, fab_mask, 64'd0);
    add_entry(OP_WRITE, 4'd0, FP_BASE + `GPIO_OFF_DDR, fp_dir, 64'd0);
    // Each masked bit follows the fabric input, the others the idle word
    for (int b = 0; b < 32; b++) begin
      if (fab_mask[b]) begin
        fp_exp[b] = fp_gpio_fab[b];
      end else begin
        fp_exp[b] = fp_idle[b];
      end
    end
    add_check(SEL_FP_OUT, 8'd0, {32'd0, fp_exp});
    add_check(SEL_FP_DDR, 8'd0, {32'd0, fp_dir});
    add_check(SEL_RB_DATA, rb_addr_of(RB_FP_GPIO), {32'd0, fp_gpio_in});
    add_check(SEL_RB_DATA, rb_addr_of(RB_DB_GPIO), {32'd0, db_gpio_in});

    // SPI loopback where the first bits sent come back right-aligned
    for (int k = 0; k < 3; k++) begin
      take_bits(8, w);
      mask = (w[7:0] == 8'd0) ? 8'h01 : w[7:0];
      add_entry(OP_WRITE, 4'd0, SPI_BASE + `SPI_OFF_DIV, 32'(spi_div[k]), 64'd0);
      add_entry(OP_WRITE, 4'd0, SPI_BASE + `SPI_OFF_CTRL, {18'd0, 6'(spi_bits[k]), mask}, 64'd0);
      take_bits(32, w);
      add_entry(OP_SPI, 4'd0, SPI_BASE + `SPI_OFF_DATA, w, 64'd0);
      add_check(SEL_RB_STB, 8'd0, 64'd0);
      add_entry(OP_WAIT, 4'd0, 8'd0, 32'd0, 64'd0);
      add_check(SEL_EDGES, 8'd0, 64'(spi_bits[k]));
      add_check(SEL_SEN_XFER, 8'd0, {56'd0, ~mask});
      add_check(SEL_SEN, 8'd0, {56'd0, 8'hFF});
      add_check(SEL_RB_DATA, rb_addr_of(RB_SPI), {32'd0, w >> (32 - spi_bits[k])});
      add_check(SEL_RB_STB, rb_addr_of(RB_LEDS), 64'd1);
    end

    cycle_limit = table_q.size() * WORST_SPI + RESET_CYCLES + 8;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    foreach (table_q[i]) begin
      apply_entry(table_q[i]);
    end
    done = 1'b1;
    @(negedge clk);
    done = 1'b0;
    @(negedge clk);
    if ((fail_count == 32'd0) && (pass_count == 32'(n_checks))) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
verilog/db_pkg.sv
verilog/gpio_atr.sv
verilog/simple_spi_core.sv
verilog/db_control.sv
sim/db_checker.sv
sim/tb_db_control.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_db_control -f sim.f -o tb_db_control_sim

output=$(./obj_dir/tb_db_control_sim)
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1
